// ==== Makefile ====
# Verilator build and run of the backup engine testbench

VERILATOR ?= verilator
TOP       ?= backup_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/backup_engine.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module backup_engine (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Cartridge and menu side
	input  logic                      downloading,
	input  logic                      cart_has_save,
	input  logic                      cram_wr,
	input  logic                      osd_status,
	input  logic                      autosave_en,
	input  logic                      load_cmd,
	input  logic                      save_cmd,
	input  bk_pkg::sector_t           ram_mask_file,
	input  logic                      rtc_inuse,
	input  bk_pkg::rtc_stamp_t        rtc_timestamp,
	input  bk_pkg::rtc_saved_t        rtc_savedtime,
	output logic                      sav_supported,
	output logic                      sav_pending,
	output logic                      bk_loading,

	// SD host side
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [`BK_IMG_SIZE_W-1:0] img_size,
	input  logic                      sd_ack,
	input  bk_pkg::buff_addr_t        sd_buff_addr,
	input  logic                      sd_buff_wr,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [`BK_SD_LBA_W-1:0]   sd_lba,
	output bk_pkg::word_t             sd_buff_din,
	output logic                      busy,

	// Backup RAM port
	input  bk_pkg::word_t             bk_q,
	output bk_pkg::bk_addr_t          bk_addr,
	output logic                      bk_wr,
	output logic                      bk_rtc_wr
);

	logic            load_req;
	logic            save_req;
	logic            clear;
	logic            advance;
	logic            last_sector;
	logic            rtc_sector;
	bk_pkg::sector_t sector;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	save_tracker u_save_tracker (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.downloading   (downloading),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.cart_has_save (cart_has_save),
		.cram_wr       (cram_wr),
		.osd_status    (osd_status),
		.autosave_en   (autosave_en),
		.load_cmd      (load_cmd),
		.save_cmd      (save_cmd),
		.busy          (busy),
		.load_req      (load_req),
		.save_req      (save_req),
		.sav_supported (sav_supported),
		.sav_pending   (sav_pending)
	);

	sector_sequencer u_sector_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_req    (load_req),
		.save_req    (save_req),
		.sd_ack      (sd_ack),
		.last_sector (last_sector),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.busy        (busy),
		.loading     (bk_loading),
		.clear       (clear),
		.advance     (advance)
	);

	sector_counter u_sector_counter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.clear       (clear),
		.advance     (advance),
		.ram_mask    (ram_mask_file),
		.rtc_inuse   (rtc_inuse),
		.sector      (sector),
		.sd_lba      (sd_lba),
		.last_sector (last_sector),
		.rtc_sector  (rtc_sector)
	);

	//////////////////////////////////////////////////
	// Data
	//////////////////////////////////////////////////

	sector_data_path u_sector_data_path (
		.sector        (sector),
		.rtc_sector    (rtc_sector),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_wr    (sd_buff_wr),
		.sd_ack        (sd_ack),
		.bk_q          (bk_q),
		.rtc_timestamp (rtc_timestamp),
		.rtc_savedtime (rtc_savedtime),
		.bk_addr       (bk_addr),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr),
		.sd_buff_din   (sd_buff_din)
	);

endmodule

// ==== design/bk_consts.svh ====
`ifndef BK_CONSTS_SVH
`define BK_CONSTS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// SD buffer and backup RAM word
`define BK_WORD_W      16
`define BK_SD_LBA_W    32
`define BK_SECTOR_W    8
// 256 words per sector
`define BK_BUFF_ADDR_W 8
`define BK_ADDR_W      17
`define BK_IMG_SIZE_W  64

//////////////////////////////////////////////////
// RTC sector layout
//////////////////////////////////////////////////

// Timestamp low/high, then saved time low/mid/high
`define BK_RTC_WORDS   5
`define BK_FILL_WORD   {`BK_WORD_W{1'b1}}

`endif

// ==== design/bk_pkg.sv ====
`include "bk_consts.svh"

package bk_pkg;

	//////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////

	typedef logic [`BK_WORD_W-1:0] word_t;
	typedef logic [`BK_SECTOR_W-1:0] sector_t;

	// Word index inside one sector
	typedef logic [`BK_BUFF_ADDR_W-1:0] buff_addr_t;

	// Sector index sits above the word index
	typedef logic [`BK_ADDR_W-1:0] bk_addr_t;

	typedef logic [31:0] rtc_stamp_t;
	typedef logic [47:0] rtc_saved_t;

	//////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		SECTOR
	} seq_state_t;

endpackage

// ==== design/save_tracker.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module save_tracker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      downloading,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [`BK_IMG_SIZE_W-1:0] img_size,
	input  logic                      cart_has_save,
	input  logic                      cram_wr,
	input  logic                      osd_status,
	input  logic                      autosave_en,
	input  logic                      load_cmd,
	input  logic                      save_cmd,
	input  logic                      busy,
	output logic                      load_req,
	output logic                      save_req,
	output logic                      sav_supported,
	output logic                      sav_pending
);

	logic bk_ena;
	logic new_load;
	logic old_downloading;
	logic dl_start;
	logic dl_end;

	assign dl_start = downloading & ~old_downloading;
	assign dl_end   = old_downloading & ~downloading;

	//////////////////////////////////////////////////
	// Backup enable and pending flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_downloading <= 1'b0;
			bk_ena          <= 1'b0;
			sav_supported   <= 1'b0;
			new_load        <= 1'b0;
			sav_pending     <= 1'b0;
		end else begin
			old_downloading <= downloading;

			// A new cartridge invalidates the old save file
			if (dl_start)
				bk_ena <= 1'b0;
			// Save image gets mounted before the download finishes
			if (downloading & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;

			sav_supported <= cart_has_save & bk_ena;

			// Load the save file once the cartridge is in place
			if (dl_end & bk_ena & (sav_supported | (|img_size)))
				new_load <= 1'b1;
			else if (busy)
				new_load <= 1'b0;

			// Game wrote its RAM outside the menu
			if (cram_wr & ~osd_status & sav_supported)
				sav_pending <= 1'b1;
			else if (busy)
				sav_pending <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Request levels to the sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_req <= 1'b0;
			save_req <= 1'b0;
		end else begin
			load_req <= bk_ena & (load_cmd | new_load);
			// Autosave fires when the menu opens
			save_req <= bk_ena & (save_cmd | (sav_pending & osd_status & autosave_en));
		end
	end

endmodule

// ==== design/sector_counter.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module sector_counter (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    clear,
	input  logic                    advance,
	input  bk_pkg::sector_t         ram_mask,
	input  logic                    rtc_inuse,
	output bk_pkg::sector_t         sector,
	output logic [`BK_SD_LBA_W-1:0] sd_lba,
	output logic                    last_sector,
	output logic                    rtc_sector
);

	localparam int LBA_PAD_W = `BK_SD_LBA_W - `BK_SECTOR_W;

	logic above_mask;
	logic at_mask;

	//////////////////////////////////////////////////
	// Sector index
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			sector <= '0;
		else if (clear)
			sector <= '0;
		else if (advance)
			sector <= sector + bk_pkg::sector_t'(1);
	end

	assign sd_lba = {{LBA_PAD_W{1'b0}}, sector};

	//////////////////////////////////////////////////
	// Mask comparisons
	//////////////////////////////////////////////////

	assign above_mask = sector > ram_mask;
	assign at_mask    = sector == ram_mask;

	// The RTC block follows the last RAM sector
	assign rtc_sector = above_mask;

	// One extra sector when the game keeps an RTC
	assign last_sector = rtc_inuse ? above_mask : (above_mask | at_mask);

endmodule

// ==== design/sector_data_path.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module sector_data_path (
	input  bk_pkg::sector_t    sector,
	input  logic               rtc_sector,
	input  bk_pkg::buff_addr_t sd_buff_addr,
	input  logic               sd_buff_wr,
	input  logic               sd_ack,
	input  bk_pkg::word_t      bk_q,
	input  bk_pkg::rtc_stamp_t rtc_timestamp,
	input  bk_pkg::rtc_saved_t rtc_savedtime,
	output bk_pkg::bk_addr_t   bk_addr,
	output logic               bk_wr,
	output logic               bk_rtc_wr,
	output bk_pkg::word_t      sd_buff_din
);

	localparam int PAD_W = `BK_ADDR_W - `BK_SECTOR_W - `BK_BUFF_ADDR_W;

	logic          buff_wr_ack;
	bk_pkg::word_t rtc_words [`BK_RTC_WORDS];

	//////////////////////////////////////////////////
	// Write routing
	//////////////////////////////////////////////////

	assign bk_addr = {{PAD_W{1'b0}}, sector, sd_buff_addr};

	assign buff_wr_ack = sd_buff_wr & sd_ack;

	// RTC sector never reaches the RAM
	assign bk_wr     = buff_wr_ack & ~rtc_sector;
	assign bk_rtc_wr = buff_wr_ack & rtc_sector;

	//////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////

	// RTC sector image in word order
	assign rtc_words[0] = rtc_timestamp[0 +: `BK_WORD_W];
	assign rtc_words[1] = rtc_timestamp[`BK_WORD_W +: `BK_WORD_W];
	assign rtc_words[2] = rtc_savedtime[0 +: `BK_WORD_W];
	assign rtc_words[3] = rtc_savedtime[`BK_WORD_W +: `BK_WORD_W];
	assign rtc_words[4] = rtc_savedtime[2*`BK_WORD_W +: `BK_WORD_W];

	always_comb begin
		sd_buff_din = `BK_FILL_WORD;
		if (!rtc_sector) begin
			sd_buff_din = bk_q;
		end else begin
			for (int i = 0; i < `BK_RTC_WORDS; i++) begin
				if (sd_buff_addr == bk_pkg::buff_addr_t'(i))
					sd_buff_din = rtc_words[i];
			end
		end
	end

endmodule

// ==== design/sector_sequencer.sv ====
`timescale 1ns/10ps

module sector_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic load_req,
	input  logic save_req,
	input  logic sd_ack,
	input  logic last_sector,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy,
	output logic loading,
	output logic clear,
	output logic advance
);

	bk_pkg::seq_state_t state;

	logic load_prev;
	logic save_prev;
	logic ack_q;
	logic ack_prev;
	logic load_rise;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic start;

	//////////////////////////////////////////////////
	// Edge detection
	//////////////////////////////////////////////////

	assign load_rise = load_req & ~load_prev;
	assign save_rise = save_req & ~save_prev;

	// Ack is sampled once before its edges are used
	assign ack_rise = ack_q & ~ack_prev;
	assign ack_fall = ~ack_q & ack_prev;

	assign start = (state == bk_pkg::IDLE) & (load_rise | save_rise);

	// Counter controls take effect on the same edge as the state change
	assign clear   = start;
	assign advance = (state == bk_pkg::SECTOR) & ack_fall & ~last_sector;
	assign busy    = state != bk_pkg::IDLE;

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= bk_pkg::IDLE;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			loading   <= 1'b0;
			load_prev <= 1'b0;
			save_prev <= 1'b0;
			ack_q     <= 1'b0;
			ack_prev  <= 1'b0;
		end else begin
			load_prev <= load_req;
			save_prev <= save_req;
			ack_q     <= sd_ack;
			ack_prev  <= ack_q;

			case (state)
				bk_pkg::IDLE: begin
					// Load wins when both rise together
					if (start) begin
						loading <= load_rise;
						sd_rd   <= load_rise;
						sd_wr   <= ~load_rise;
						state   <= bk_pkg::REQUEST;
					end
				end

				bk_pkg::REQUEST: begin
					// Host has taken the sector
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= bk_pkg::SECTOR;
					end
				end

				bk_pkg::SECTOR: begin
					if (ack_fall) begin
						if (last_sector) begin
							loading <= 1'b0;
							state   <= bk_pkg::IDLE;
						end else begin
							sd_rd <= loading;
							sd_wr <= ~loading;
							state <= bk_pkg::REQUEST;
						end
					end
				end

				default: state <= bk_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== sim.f ====
+incdir+design
design/bk_pkg.sv
design/save_tracker.sv
design/sector_counter.sv
design/sector_sequencer.sv
design/sector_data_path.sv
design/backup_engine.sv
verification/sd_host_model.sv
verification/backup_tb.sv

// ==== verification/backup_tb.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module backup_tb;

	localparam int NUM_RANDOM    = 8;
	localparam int NUM_TESTS     = NUM_RANDOM + 3;
	localparam int MAX_MASK      = 15;
	localparam int MAX_ACK_DELAY = 8;
	localparam int MAX_GAP       = 2;
	localparam int START_CYCLES  = 16;
	localparam int CLK_PERIOD    = 8;
	localparam int SECTOR_CYCLES = MAX_ACK_DELAY + (1 << `BK_BUFF_ADDR_W) * (MAX_GAP + 1) + 8;
	localparam int XFER_CYCLES   = (MAX_MASK + 2) * SECTOR_CYCLES;
	localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 1) * XFER_CYCLES * CLK_PERIOD;

	logic                      clk_sys;
	logic                      reset;
	logic                      downloading;
	logic                      cart_has_save;
	logic                      cram_wr;
	logic                      osd_status;
	logic                      autosave_en;
	logic                      load_cmd;
	logic                      save_cmd;
	bk_pkg::sector_t           ram_mask_file;
	logic                      rtc_inuse;
	bk_pkg::rtc_stamp_t        rtc_timestamp;
	bk_pkg::rtc_saved_t        rtc_savedtime;
	logic                      sav_supported;
	logic                      sav_pending;
	logic                      bk_loading;
	logic                      img_mounted;
	logic                      img_readonly;
	logic [`BK_IMG_SIZE_W-1:0] img_size;
	logic                      sd_ack;
	bk_pkg::buff_addr_t        sd_buff_addr;
	logic                      sd_buff_wr;
	bk_pkg::word_t             sd_buff_dout;
	logic                      sd_rd;
	logic                      sd_wr;
	logic [`BK_SD_LBA_W-1:0]   sd_lba;
	bk_pkg::word_t             sd_buff_din;
	logic                      busy;
	bk_pkg::word_t             bk_q;
	bk_pkg::bk_addr_t          bk_addr;
	logic                      bk_wr;
	logic                      bk_rtc_wr;

	// Backup RAM seen by the DUT, and the expected contents
	bk_pkg::word_t    bram [1 << `BK_ADDR_W];
	bk_pkg::word_t    exp_ram [1 << `BK_ADDR_W];
	logic             exp_read;
	logic             in_rtc;
	bk_pkg::bk_addr_t exp_addr;
	bk_pkg::word_t    exp_word;
	int               xfer_first;
	int               cur_sector;
	int               errors;
	int               words;

	backup_engine dut (.*);

	sd_host_model #(
		.MAX_DELAY (MAX_ACK_DELAY),
		.MAX_GAP   (MAX_GAP)
	) host (
		.clk_sys      (clk_sys),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_dout (sd_buff_dout)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	assign bk_q = bram[bk_addr];

	always @(posedge clk_sys) begin
		if (bk_wr)
			bram[bk_addr] <= sd_buff_dout;
	end

	function automatic bk_pkg::word_t fill_word(input bk_pkg::bk_addr_t a);
		return bk_pkg::word_t'(a ^ (a >> 7) ^ 17'h0a5c3);
	endfunction

	// RTC sector image
	function automatic bk_pkg::word_t rtc_word(input int idx);
		case (idx)
			0: return rtc_timestamp[15:0];
			1: return rtc_timestamp[31:16];
			2: return rtc_savedtime[15:0];
			3: return rtc_savedtime[31:16];
			4: return rtc_savedtime[47:32];
			default: return `BK_FILL_WORD;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Per-word monitor during ack
	//////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		if (!reset && sd_ack) begin
			// Sector position within the transfer, counted from the host's requests
			cur_sector = host.rec_count - xfer_first - 1;
			in_rtc     = rtc_inuse && (cur_sector > int'(ram_mask_file));
			exp_addr   = bk_pkg::bk_addr_t'({bk_pkg::sector_t'(cur_sector), sd_buff_addr});
			if (exp_read) begin
				if (bk_wr !== (sd_buff_wr && !in_rtc)) begin
					$display("Error: bk_wr = %h, expected %h", bk_wr, sd_buff_wr && !in_rtc);
					errors++;
				end
				if (bk_rtc_wr !== (sd_buff_wr && in_rtc)) begin
					$display("Error: bk_rtc_wr = %h, expected %h", bk_rtc_wr,
						sd_buff_wr && in_rtc);
					errors++;
				end
				if (sd_buff_wr && !in_rtc) begin
					if (bk_addr !== exp_addr) begin
						$display("Error: bk_addr = %h, expected %h", bk_addr, exp_addr);
						errors++;
					end
					exp_ram[exp_addr] = sd_buff_dout;
					words++;
				end
			end else begin
				exp_word = in_rtc ? rtc_word(int'(sd_buff_addr)) : exp_ram[exp_addr];
				if (sd_buff_din !== exp_word) begin
					$display("Error: sd_buff_din = %h, expected %h at sector %h word %h",
						sd_buff_din, exp_word, cur_sector, sd_buff_addr);
					errors++;
				end
				words++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic new_setup();
		@(negedge clk_sys);
		ram_mask_file = bk_pkg::sector_t'($urandom_range(0, MAX_MASK));
		rtc_inuse     = ($urandom_range(0, 1) != 0);
		rtc_timestamp = $urandom;
		rtc_savedtime = {16'($urandom), $urandom};
	endtask

	task automatic run_download(input logic ro);
		@(negedge clk_sys);
		img_mounted  = 1'b1;
		img_readonly = ro;
		img_size     = 64'($urandom_range(1, 255));
		downloading  = 1'b1;
		repeat (4) @(negedge clk_sys);
		downloading = 1'b0;
	endtask

	task automatic pulse_cmd(input logic rd);
		@(negedge clk_sys);
		load_cmd = rd;
		save_cmd = !rd;
		@(negedge clk_sys);
		load_cmd = 1'b0;
		save_cmd = 1'b0;
	endtask

	task automatic expect_idle(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk_sys);
			if (busy !== 1'b0) begin
				$display("Error: busy = %h, expected %h with a read-only image", busy, 1'b0);
				errors++;
				return;
			end
		end
	endtask

	// Waits for one whole transfer and checks the sectors the host saw
	task automatic run_transfer(input logic rd);
		int first;
		int waited;
		int count;
		int exp_count;
		first      = host.rec_count;
		xfer_first = first;
		exp_read   = rd;
		waited     = 0;
		while (!busy && waited < START_CYCLES) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!busy) begin
			$display("Transfer did not start within %0d cycles", START_CYCLES);
			errors++;
			return;
		end
		if (bk_loading !== rd) begin
			$display("Error: bk_loading = %h, expected %h", bk_loading, rd);
			errors++;
		end
		waited = 0;
		while (busy && waited < XFER_CYCLES) begin
			@(negedge clk_sys);
			waited++;
		end
		if (busy) begin
			$display("Transfer did not finish within %0d cycles", XFER_CYCLES);
			errors++;
			return;
		end
		count     = host.rec_count - first;
		exp_count = int'(ram_mask_file) + (rtc_inuse ? 2 : 1);
		if (count != exp_count) begin
			$display("Error: sector count = %h, expected %h", count, exp_count);
			errors++;
		end
		for (int k = 0; k < count && k < exp_count; k++) begin
			if (host.rec_lba[first + k] !== k) begin
				$display("Error: sd_lba = %h, expected %h", host.rec_lba[first + k], k);
				errors++;
			end
			if (host.rec_read[first + k] !== rd) begin
				$display("Error: sd_rd = %h, expected %h", host.rec_read[first + k], rd);
				errors++;
			end
			if (host.rec_write[first + k] !== !rd) begin
				$display("Error: sd_wr = %h, expected %h", host.rec_write[first + k], !rd);
				errors++;
			end
		end
		if (bk_loading !== 1'b0) begin
			$display("Error: bk_loading = %h, expected %h", bk_loading, 1'b0);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h3aa8));
		clk_sys       = 1'b0;
		reset         = 1'b1;
		downloading   = 1'b0;
		cart_has_save = 1'b1;
		cram_wr       = 1'b0;
		osd_status    = 1'b0;
		autosave_en   = 1'b0;
		load_cmd      = 1'b0;
		save_cmd      = 1'b0;
		ram_mask_file = '0;
		rtc_inuse     = 1'b0;
		rtc_timestamp = '0;
		rtc_savedtime = '0;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_size      = '0;
		exp_read      = 1'b1;
		xfer_first    = 0;
		errors        = 0;
		words         = 0;
		for (int a = 0; a < (1 << `BK_ADDR_W); a++) begin
			exp_ram[a] = fill_word(bk_pkg::bk_addr_t'(a));
			bram[a]   <= fill_word(bk_pkg::bk_addr_t'(a));
		end
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		if ({sd_rd, sd_wr, busy, bk_loading, sav_pending} !== 5'b0) begin
			$display("Error: {sd_rd, sd_wr, busy, bk_loading, sav_pending} = %h, expected %h",
				{sd_rd, sd_wr, busy, bk_loading, sav_pending}, 5'b0);
			errors++;
		end

		// Read-only image blocks every transfer
		run_download(1'b1);
		pulse_cmd(1'b1);
		pulse_cmd(1'b0);
		expect_idle(4 * START_CYCLES);
		if (sav_supported !== 1'b0) begin
			$display("Error: sav_supported = %h, expected %h", sav_supported, 1'b0);
			errors++;
		end

		// End of a writable download loads by itself
		new_setup();
		run_download(1'b0);
		run_transfer(1'b1);
		if (sav_supported !== 1'b1) begin
			$display("Error: sav_supported = %h, expected %h", sav_supported, 1'b1);
			errors++;
		end

		for (int t = 0; t < NUM_RANDOM; t++) begin
			new_setup();
			exp_read = ($urandom_range(0, 1) != 0);
			pulse_cmd(exp_read);
			run_transfer(exp_read);
		end

		// Game RAM write with the menu closed, then autosave on menu open
		@(negedge clk_sys);
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		@(negedge clk_sys);
		if (sav_pending !== 1'b1) begin
			$display("Error: sav_pending = %h, expected %h", sav_pending, 1'b1);
			errors++;
		end
		autosave_en = 1'b1;
		osd_status  = 1'b1;
		run_transfer(1'b0);
		if (sav_pending !== 1'b0) begin
			$display("Error: sav_pending = %h, expected %h", sav_pending, 1'b0);
			errors++;
		end
		osd_status = 1'b0;

		$display("Words checked: %0d, errors: %0d", words, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== verification/sd_host_model.sv ====
`timescale 1ns/10ps
`include "bk_consts.svh"

module sd_host_model #(
	parameter int MAX_DELAY = 8,
	parameter int MAX_GAP   = 2,
	parameter int MAX_RECS  = 1024
) (
	input  logic                    clk_sys,
	input  logic                    sd_rd,
	input  logic                    sd_wr,
	input  logic [`BK_SD_LBA_W-1:0] sd_lba,
	output logic                    sd_ack,
	output bk_pkg::buff_addr_t      sd_buff_addr,
	output logic                    sd_buff_wr,
	output bk_pkg::word_t           sd_buff_dout
);

	// Sectors seen so far, in request order
	logic [`BK_SD_LBA_W-1:0] rec_lba [MAX_RECS];
	logic                    rec_read [MAX_RECS];
	logic                    rec_write [MAX_RECS];
	int                      rec_count;

	logic is_read;

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		is_read      = 1'b0;
		rec_count    = 0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd | sd_wr) begin
				is_read = sd_rd;
				if (rec_count < MAX_RECS) begin
					rec_lba[rec_count]   = sd_lba;
					rec_read[rec_count]  = sd_rd;
					rec_write[rec_count] = sd_wr;
				end
				rec_count++;
				repeat ($urandom_range(0, MAX_DELAY)) @(negedge clk_sys);

				// One full sector while ack is held
				sd_ack = 1'b1;
				for (int i = 0; i < (1 << `BK_BUFF_ADDR_W); i++) begin
					sd_buff_addr = bk_pkg::buff_addr_t'(i);
					sd_buff_wr   = is_read;
					if (is_read)
						sd_buff_dout = bk_pkg::word_t'($urandom);
					@(negedge clk_sys);
					sd_buff_wr = 1'b0;
					repeat ($urandom_range(0, MAX_GAP)) @(negedge clk_sys);
				end
				sd_ack = 1'b0;
			end
		end
	end

endmodule
